//--- hw/radio_fe_pkg.sv
//////////////////////////////
// radio front end shared definitions
// widths, register map and bus/pin/sample types
//////////////////////////////

package radio_fe_pkg;

   localparam int NUM_CHANNELS = 4;
   localparam int NUM_DBOARDS  = 2;
   localparam int SAMPLE_W     = 32;
   localparam int IQ_W         = SAMPLE_W / 2;
   localparam int SET_ADDR_W   = 8;
   localparam int SET_DATA_W   = 32;
   localparam int RB_DATA_W    = 64;
   localparam int LED_W        = 3;   // {rx, txrx_tx, txrx_rx}

   // settings write addresses
   localparam logic [SET_ADDR_W-1:0] SR_FE_CTRL  = 8'd0;
   localparam logic [SET_ADDR_W-1:0] SR_GPIO_OUT = 8'd1;
   localparam logic [SET_ADDR_W-1:0] SR_GPIO_DDR = 8'd2;
   localparam logic [SET_ADDR_W-1:0] SR_LEDS     = 8'd3;
   localparam logic [SET_ADDR_W-1:0] SR_MISC_OUT = 8'd4;

   // readback addresses
   localparam logic [SET_ADDR_W-1:0] RB_GPIO = 8'd0;
   localparam logic [SET_ADDR_W-1:0] RB_MISC = 8'd1;
   localparam logic [SET_ADDR_W-1:0] RB_FE   = 8'd2;

   typedef struct packed {
      logic                  stb;
      logic [SET_ADDR_W-1:0] addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   // low bits of SR_FE_CTRL, swap_iq is bit 2
   typedef struct packed {
      logic swap_iq;
      logic invert_i;
      logic invert_q;
   } fe_ctrl_t;

   typedef struct packed {
      logic [SET_DATA_W-1:0] gpio_out;
      logic [SET_DATA_W-1:0] gpio_ddr;
      logic [LED_W-1:0]      leds;
      logic [SET_DATA_W-1:0] misc_out;
   } fe_pins_out_t;

   typedef struct packed {
      logic [SET_DATA_W-1:0] gpio_in;
      logic [SET_DATA_W-1:0] misc_in;
   } fe_pins_in_t;

   typedef struct packed {
      logic [IQ_W-1:0] i;   // upper half
      logic [IQ_W-1:0] q;
   } iq_t;

   typedef union packed {
      logic [SAMPLE_W-1:0] raw;
      iq_t                 iq;
   } sample_u;

endpackage

//--- hw/radio_timing_sync.sv
//////////////////////////////
// pps and time-sync synchronizer
// brings both inputs into radio_clk, pps edge becomes a one-cycle pulse
//////////////////////////////

`timescale 1ns/1ps

module radio_timing_sync (
   input  logic radio_clk,
   input  logic i_reset,
   input  logic i_pps,
   input  logic i_time_sync,
   output logic o_pps_pulse,
   output logic o_time_sync
);

   logic pps_meta, pps_sync, pps_dly;
   logic ts_meta, ts_sync;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         pps_meta    <= 1'b0;
         pps_sync    <= 1'b0;
         pps_dly     <= 1'b0;
         o_pps_pulse <= 1'b0;
         ts_meta     <= 1'b0;
         ts_sync     <= 1'b0;
      end else begin
         pps_meta    <= i_pps;      // async input, two stages
         pps_sync    <= pps_meta;
         pps_dly     <= pps_sync;   // edge detect
         o_pps_pulse <= pps_sync & ~pps_dly;
         ts_meta     <= i_time_sync;
         ts_sync     <= ts_meta;
      end
   end

   assign o_time_sync = ts_sync;

   // one pulse per rising edge, however long pps stays high
   a_pps_single : assert property (
      @(posedge radio_clk) disable iff (i_reset)
      o_pps_pulse |=> !o_pps_pulse
   );

endmodule

//--- hw/fe_settings_regs.sv
//////////////////////////////
// per-channel front end registers
// settings bus writes and registered readback mux
//////////////////////////////

`timescale 1ns/1ps

module fe_settings_regs (
   input  logic                                        radio_clk,
   input  logic                                        i_reset,
   input  radio_fe_pkg::set_bus_t                      i_set,
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0]         i_rb_addr,
   input  radio_fe_pkg::fe_pins_in_t                   i_pins,
   output logic [radio_fe_pkg::RB_DATA_W-1:0]          o_rb_data,
   output radio_fe_pkg::fe_pins_out_t                  o_pins,
   output radio_fe_pkg::fe_ctrl_t                      o_fe_ctrl
);

   import radio_fe_pkg::*;

   localparam int HALF_W = RB_DATA_W / 2;
   localparam int CTRL_W = $bits(fe_ctrl_t);

   fe_ctrl_t              fe_ctrl_r;
   logic [SET_DATA_W-1:0] gpio_out_r;
   logic [SET_DATA_W-1:0] gpio_ddr_r;
   logic [LED_W-1:0]      leds_r;
   logic [SET_DATA_W-1:0] misc_out_r;
   logic [RB_DATA_W-1:0]  rb_next;

   //////////////////////////////
   // register writes
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         fe_ctrl_r  <= '0;
         gpio_out_r <= '0;
         gpio_ddr_r <= '0;
         leds_r     <= '0;
         misc_out_r <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            SR_FE_CTRL:  fe_ctrl_r  <= fe_ctrl_t'(i_set.data[CTRL_W-1:0]);
            SR_GPIO_OUT: gpio_out_r <= i_set.data;
            SR_GPIO_DDR: gpio_ddr_r <= i_set.data;
            SR_LEDS:     leds_r     <= i_set.data[LED_W-1:0];
            SR_MISC_OUT: misc_out_r <= i_set.data;
            default: ;   // unmapped, dropped
         endcase
      end
   end

   //////////////////////////////
   // readback
   //////////////////////////////
   always_comb begin
      case (i_rb_addr)
         RB_GPIO: rb_next = {i_pins.gpio_in, gpio_out_r};
         RB_MISC: rb_next = {i_pins.misc_in, misc_out_r};
         RB_FE: begin
            rb_next = {{(HALF_W - CTRL_W){1'b0}}, fe_ctrl_r,
                       {(HALF_W - LED_W){1'b0}}, leds_r};
         end
         default: rb_next = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rb_data <= '0;
      end else begin
         o_rb_data <= rb_next;
      end
   end

   assign o_pins.gpio_out = gpio_out_r;
   assign o_pins.gpio_ddr = gpio_ddr_r;
   assign o_pins.leds     = leds_r;
   assign o_pins.misc_out = misc_out_r;
   assign o_fe_ctrl       = fe_ctrl_r;

   // the driving radio core must never strobe with a floating address
   a_set_addr_known : assert property (
      @(posedge radio_clk) disable iff (i_reset)
      i_set.stb |-> !$isunknown(i_set.addr)
   );

endmodule

//--- hw/fe_iq_correct.sv
//////////////////////////////
// i/q correction stage
// optional swap and per-rail negate, one register
//////////////////////////////

`timescale 1ns/1ps

module fe_iq_correct (
   input  logic                                  radio_clk,
   input  logic                                  i_reset,
   input  radio_fe_pkg::fe_ctrl_t                i_ctrl,
   input  logic                                  i_valid,
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]     i_sample,
   output logic                                  o_valid,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]     o_sample
);

   import radio_fe_pkg::*;

   sample_u in_w;
   iq_t     swapped;
   sample_u corr;

   always_comb begin
      in_w.raw = i_sample;
      // swap first, then invert
      swapped  = i_ctrl.swap_iq ? iq_t'{i: in_w.iq.q, q: in_w.iq.i} : in_w.iq;
      corr.iq.i = i_ctrl.invert_i ? IQ_W'(-swapped.i) : swapped.i;   // -32768 wraps to itself
      corr.iq.q = i_ctrl.invert_q ? IQ_W'(-swapped.q) : swapped.q;
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_valid  <= 1'b0;
         o_sample <= '0;
      end else begin
         o_valid  <= i_valid;
         o_sample <= i_valid ? corr.raw : '0;   // zero when idle
      end
   end

   a_valid_latency : assert property (
      @(posedge radio_clk) disable iff (i_reset)
      !$past(i_reset) |-> (o_valid == $past(i_valid))
   );

endmodule

//--- hw/db_pin_map.sv
//////////////////////////////
// daughterboard pin map
// even channel owns the pins, leds of a pair are ORed
//////////////////////////////

`timescale 1ns/1ps

module db_pin_map (
   input  logic                                     radio_clk,
   input  logic                                     i_reset,
   input  radio_fe_pkg::fe_pins_out_t               i_ch_pins     [radio_fe_pkg::NUM_CHANNELS],
   output radio_fe_pkg::fe_pins_in_t                o_ch_pins     [radio_fe_pkg::NUM_CHANNELS],
   input  logic [radio_fe_pkg::SET_DATA_W-1:0]      i_db_gpio_in  [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::SET_DATA_W-1:0]      o_db_gpio_out [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::SET_DATA_W-1:0]      o_db_gpio_ddr [radio_fe_pkg::NUM_DBOARDS],
   input  logic [radio_fe_pkg::SET_DATA_W-1:0]      i_misc_in     [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::SET_DATA_W-1:0]      o_misc_out    [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::LED_W-1:0]           o_radio_led   [radio_fe_pkg::NUM_DBOARDS]
);

   import radio_fe_pkg::*;

   logic [SET_DATA_W-1:0] misc_out_r [NUM_DBOARDS];
   logic [SET_DATA_W-1:0] misc_in_r  [NUM_DBOARDS];

   //////////////////////////////
   // misc words, one flop each way
   //////////////////////////////
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            misc_out_r[d] <= '0;
            misc_in_r[d]  <= '0;
         end
      end else begin
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            misc_out_r[d] <= i_ch_pins[2*d].misc_out;
            misc_in_r[d]  <= i_misc_in[d];
         end
      end
   end

   //////////////////////////////
   // per-board mapping
   //////////////////////////////
   genvar d;
   generate
      for (d = 0; d < NUM_DBOARDS; d++) begin : g_db
         assign o_db_gpio_out[d] = i_ch_pins[2*d].gpio_out;   // odd channel unused
         assign o_db_gpio_ddr[d] = i_ch_pins[2*d].gpio_ddr;
         assign o_misc_out[d]    = misc_out_r[d];

         // both channels share the leds, show the overlay
         assign o_radio_led[d] = i_ch_pins[2*d].leds | i_ch_pins[2*d+1].leds;

         assign o_ch_pins[2*d].gpio_in   = i_db_gpio_in[d];
         assign o_ch_pins[2*d].misc_in   = misc_in_r[d];
         assign o_ch_pins[2*d+1].gpio_in = '0;   // odd channel sees no pins
         assign o_ch_pins[2*d+1].misc_in = '0;
      end
   endgenerate

endmodule

//--- hw/x300_radio_frontend.sv
//////////////////////////////
// radio-clock front end top
// four channel regs and correction, pin map, pps/time sync
//////////////////////////////

`timescale 1ns/1ps

module x300_radio_frontend (
   input  logic                                  radio_clk,
   input  logic                                  i_reset,
   // timing
   input  logic                                  i_pps,
   input  logic                                  i_time_sync,
   output logic                                  o_pps_pulse,
   output logic                                  o_time_sync,
   // settings per channel
   input  radio_fe_pkg::set_bus_t                i_set        [radio_fe_pkg::NUM_CHANNELS],
   input  logic [radio_fe_pkg::SET_ADDR_W-1:0]   i_rb_addr    [radio_fe_pkg::NUM_CHANNELS],
   output logic [radio_fe_pkg::RB_DATA_W-1:0]    o_rb_data    [radio_fe_pkg::NUM_CHANNELS],
   // rx samples
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]     i_adc        [radio_fe_pkg::NUM_DBOARDS],
   input  logic [radio_fe_pkg::NUM_CHANNELS-1:0] i_rx_running,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]     o_rx_sample  [radio_fe_pkg::NUM_CHANNELS],
   output logic [radio_fe_pkg::NUM_CHANNELS-1:0] o_rx_valid,
   // tx samples
   input  logic [radio_fe_pkg::SAMPLE_W-1:0]     i_tx_sample  [radio_fe_pkg::NUM_DBOARDS],
   input  logic [radio_fe_pkg::NUM_DBOARDS-1:0]  i_tx_valid,
   output logic [radio_fe_pkg::SAMPLE_W-1:0]     o_dac        [radio_fe_pkg::NUM_DBOARDS],
   // daughterboard pins
   input  logic [radio_fe_pkg::SET_DATA_W-1:0]   i_db_gpio_in  [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::SET_DATA_W-1:0]   o_db_gpio_out [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::SET_DATA_W-1:0]   o_db_gpio_ddr [radio_fe_pkg::NUM_DBOARDS],
   input  logic [radio_fe_pkg::SET_DATA_W-1:0]   i_misc_in     [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::SET_DATA_W-1:0]   o_misc_out    [radio_fe_pkg::NUM_DBOARDS],
   output logic [radio_fe_pkg::LED_W-1:0]        o_radio_led   [radio_fe_pkg::NUM_DBOARDS]
);

   import radio_fe_pkg::*;

   fe_pins_out_t ch_pins_out [NUM_CHANNELS];
   fe_pins_in_t  ch_pins_in  [NUM_CHANNELS];
   fe_ctrl_t     fe_ctrl     [NUM_CHANNELS];

   radio_timing_sync u_timing (
      .radio_clk   (radio_clk),
      .i_reset     (i_reset),
      .i_pps       (i_pps),
      .i_time_sync (i_time_sync),
      .o_pps_pulse (o_pps_pulse),
      .o_time_sync (o_time_sync)
   );

   //////////////////////////////
   // channels
   //////////////////////////////
   genvar ch;
   generate
      for (ch = 0; ch < NUM_CHANNELS; ch++) begin : g_ch
         fe_settings_regs u_regs (
            .radio_clk (radio_clk),
            .i_reset   (i_reset),
            .i_set     (i_set[ch]),
            .i_rb_addr (i_rb_addr[ch]),
            .i_pins    (ch_pins_in[ch]),
            .o_rb_data (o_rb_data[ch]),
            .o_pins    (ch_pins_out[ch]),
            .o_fe_ctrl (fe_ctrl[ch])
         );

         // adc word of the board feeds both channels of the pair
         fe_iq_correct u_rx_corr (
            .radio_clk (radio_clk),
            .i_reset   (i_reset),
            .i_ctrl    (fe_ctrl[ch]),
            .i_valid   (i_rx_running[ch]),
            .i_sample  (i_adc[ch/2]),
            .o_valid   (o_rx_valid[ch]),
            .o_sample  (o_rx_sample[ch])
         );
      end
   endgenerate

   //////////////////////////////
   // tx, even channel controls
   //////////////////////////////
   genvar db;
   generate
      for (db = 0; db < NUM_DBOARDS; db++) begin : g_tx
         fe_iq_correct u_tx_corr (
            .radio_clk (radio_clk),
            .i_reset   (i_reset),
            .i_ctrl    (fe_ctrl[2*db]),
            .i_valid   (i_tx_valid[db]),
            .i_sample  (i_tx_sample[db]),
            .o_valid   (),   // dac takes a word every cycle
            .o_sample  (o_dac[db])
         );
      end
   endgenerate

   db_pin_map u_pin_map (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .i_ch_pins     (ch_pins_out),
      .o_ch_pins     (ch_pins_in),
      .i_db_gpio_in  (i_db_gpio_in),
      .o_db_gpio_out (o_db_gpio_out),
      .o_db_gpio_ddr (o_db_gpio_ddr),
      .i_misc_in     (i_misc_in),
      .o_misc_out    (o_misc_out),
      .o_radio_led   (o_radio_led)
   );

endmodule

//--- tb/tb_ref_model.svh
//////////////////////////////
// reference model for the front end testbench
// i/q correction, readback word and led overlay
//////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 16-bit two's complement, -32768 maps onto itself
function automatic logic [15:0] negate16(input logic [15:0] v);
   return ~v + 16'd1;
endfunction

// ctrl is {swap_iq, invert_i, invert_q}
function automatic logic [31:0] corrected_word(input logic [2:0] ctrl, input logic valid,
                                               input logic [31:0] word);
   logic [15:0] i_part;
   logic [15:0] q_part;
   logic [15:0] tmp;
   if (!valid) return 32'd0;   // idle lane outputs zero
   i_part = word[31:16];
   q_part = word[15:0];
   if (ctrl[2]) begin
      tmp    = i_part;
      i_part = q_part;
      q_part = tmp;
   end
   if (ctrl[1]) i_part = negate16(i_part);
   if (ctrl[0]) q_part = negate16(q_part);
   return {i_part, q_part};
endfunction

function automatic logic [63:0] expected_readback(input logic [7:0] addr,
      input logic [31:0] gpio_in, input logic [31:0] gpio_out, input logic [31:0] misc_in,
      input logic [31:0] misc_out, input logic [2:0] ctrl, input logic [2:0] leds);
   case (addr)
      RB_GPIO: return {gpio_in, gpio_out};
      RB_MISC: return {misc_in, misc_out};
      RB_FE:   return {29'd0, ctrl, 29'd0, leds};
      default: return 64'd0;
   endcase
endfunction

function automatic logic [2:0] led_overlay(input logic [2:0] even_leds, input logic [2:0] odd_leds);
   return even_leds | odd_leds;
endfunction

`endif

//--- tb/tb_x300_radio_frontend.sv
//////////////////////////////
// testbench for the radio front end top
//////////////////////////////

`timescale 1ns/1ps

module tb_x300_radio_frontend;

   import radio_fe_pkg::*;

   localparam int TIMEOUT_CYCLES = 5000;   // tests need about 120 cycles

   `include "tb_ref_model.svh"

   logic radio_clk, i_reset, pps, time_sync, pps_pulse, time_sync_out;
   set_bus_t                set_bus   [NUM_CHANNELS];
   logic [SET_ADDR_W-1:0]   rb_addr   [NUM_CHANNELS];
   logic [RB_DATA_W-1:0]    rb_data   [NUM_CHANNELS];
   logic [SAMPLE_W-1:0]     adc       [NUM_DBOARDS];
   logic [NUM_CHANNELS-1:0] rx_running, rx_valid;
   logic [SAMPLE_W-1:0]     rx_sample [NUM_CHANNELS];
   logic [SAMPLE_W-1:0]     tx_sample [NUM_DBOARDS];
   logic [NUM_DBOARDS-1:0]  tx_valid;
   logic [SAMPLE_W-1:0]     dac       [NUM_DBOARDS];
   logic [SET_DATA_W-1:0]   gpio_in   [NUM_DBOARDS];
   logic [SET_DATA_W-1:0]   gpio_out  [NUM_DBOARDS];
   logic [SET_DATA_W-1:0]   gpio_ddr  [NUM_DBOARDS];
   logic [SET_DATA_W-1:0]   misc_in   [NUM_DBOARDS];
   logic [SET_DATA_W-1:0]   misc_out  [NUM_DBOARDS];
   logic [LED_W-1:0]        radio_led [NUM_DBOARDS];

   // expected register contents per channel
   logic [2:0]  m_ctrl     [NUM_CHANNELS];
   logic [31:0] m_gpio_out [NUM_CHANNELS];
   logic [31:0] m_gpio_ddr [NUM_CHANNELS];
   logic [2:0]  m_leds     [NUM_CHANNELS];
   logic [31:0] m_misc_out [NUM_CHANNELS];
   logic [31:0] wr_data    [NUM_CHANNELS];

   string       chk_name_q [$];
   logic [63:0] chk_exp_q  [$];
   logic [63:0] chk_act_q  [$];
   string       cur_name;
   logic [63:0] cur_exp, cur_act;
   integer      seed;
   int          checks = 0;
   int          errors = 0;
   int          cycle_cnt = 0;

   initial begin
      radio_clk = 1'b0;
      forever #5 radio_clk = ~radio_clk;
   end

   x300_radio_frontend dut_i (
      .radio_clk (radio_clk), .i_reset (i_reset),
      .i_pps (pps), .i_time_sync (time_sync),
      .o_pps_pulse (pps_pulse), .o_time_sync (time_sync_out),
      .i_set (set_bus), .i_rb_addr (rb_addr), .o_rb_data (rb_data),
      .i_adc (adc), .i_rx_running (rx_running), .o_rx_sample (rx_sample), .o_rx_valid (rx_valid),
      .i_tx_sample (tx_sample), .i_tx_valid (tx_valid), .o_dac (dac),
      .i_db_gpio_in (gpio_in), .o_db_gpio_out (gpio_out), .o_db_gpio_ddr (gpio_ddr),
      .i_misc_in (misc_in), .o_misc_out (misc_out), .o_radio_led (radio_led)
   );

   task automatic expect_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      chk_name_q.push_back(name);
      chk_exp_q.push_back(exp);
      chk_act_q.push_back(act);
   endtask

   task automatic fill_random();
      for (int c = 0; c < NUM_CHANNELS; c++) wr_data[c] = $random(seed);
   endtask

   // wr_data goes to every channel on one edge
   task automatic write_all(input logic [SET_ADDR_W-1:0] addr);
      for (int c = 0; c < NUM_CHANNELS; c++)
         set_bus[c] = '{stb: 1'b1, addr: addr, data: wr_data[c]};
      @(negedge radio_clk);
      // misc flop still shows the register as it was before this edge
      for (int d = 0; d < NUM_DBOARDS; d++)
         expect_value($sformatf("misc_out lag db%0d", d), 64'(m_misc_out[2*d]),
                      64'(misc_out[d]));
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         set_bus[c].stb = 1'b0;
         case (addr)
            SR_FE_CTRL:  m_ctrl[c]     = wr_data[c][2:0];
            SR_GPIO_OUT: m_gpio_out[c] = wr_data[c];
            SR_GPIO_DDR: m_gpio_ddr[c] = wr_data[c];
            SR_LEDS:     m_leds[c]     = wr_data[c][2:0];
            SR_MISC_OUT: m_misc_out[c] = wr_data[c];
            default: ;
         endcase
      end
   endtask

   task automatic check_readback(input logic [SET_ADDR_W-1:0] addr);
      for (int c = 0; c < NUM_CHANNELS; c++) rb_addr[c] = addr;
      @(posedge radio_clk);
      #1;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         expect_value($sformatf("readback ch%0d addr%0d", c, addr),
            expected_readback(addr, (c % 2 == 0) ? gpio_in[c/2] : 32'd0, m_gpio_out[c],
                              (c % 2 == 0) ? misc_in[c/2] : 32'd0, m_misc_out[c],
                              m_ctrl[c], m_leds[c]),
            rb_data[c]);
      end
      @(negedge radio_clk);
   endtask

   // pin outputs one edge after the last write
   task automatic check_pins();
      @(posedge radio_clk);
      #1;
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         expect_value($sformatf("gpio_out db%0d", d), 64'(m_gpio_out[2*d]), 64'(gpio_out[d]));
         expect_value($sformatf("gpio_ddr db%0d", d), 64'(m_gpio_ddr[2*d]), 64'(gpio_ddr[d]));
         expect_value($sformatf("misc_out db%0d", d), 64'(m_misc_out[2*d]), 64'(misc_out[d]));
         expect_value($sformatf("led db%0d", d),
                      64'(led_overlay(m_leds[2*d], m_leds[2*d+1])), 64'(radio_led[d]));
      end
      @(negedge radio_clk);
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////
   initial begin
      seed = 71;
      i_reset = 1'b1;
      pps = 1'b0;
      time_sync = 1'b0;
      rx_running = '0;
      tx_valid = '0;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         set_bus[c] = '0;
         rb_addr[c] = '0;
         m_ctrl[c] = '0;
         m_gpio_out[c] = '0;
         m_gpio_ddr[c] = '0;
         m_leds[c] = '0;
         m_misc_out[c] = '0;
      end
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         adc[d] = '0;
         tx_sample[d] = '0;
         gpio_in[d] = '0;
         misc_in[d] = '0;
      end
      repeat (2) @(posedge radio_clk);
      @(negedge radio_clk);
      i_reset = 1'b0;
      @(posedge radio_clk);
      #1;
      expect_value("reset rx_valid", 64'd0, 64'(rx_valid));
      expect_value("reset pps_pulse", 64'd0, 64'(pps_pulse));
      expect_value("reset dac0", 64'd0, 64'(dac[0]));
      expect_value("reset rb0", 64'd0, rb_data[0]);
      @(negedge radio_clk);

      // register writes, pin map and readback
      for (int round = 0; round < 4; round++) begin
         for (int a = 0; a < 6; a++) begin
            fill_random();
            write_all((a == 5) ? 8'h09 : 8'(a));   // last one is unmapped
         end
         check_pins();
         for (int d = 0; d < NUM_DBOARDS; d++) begin
            gpio_in[d] = $random(seed);
            misc_in[d] = $random(seed);
         end
         // gpio reads back on the next edge, misc one edge later
         for (int a = 0; a < 5; a++) check_readback((a == 4) ? 8'hff : 8'(a));
      end

      for (int n = 0; n < 6; n++) begin
         fill_random();
         write_all(SR_LEDS);
         check_pins();
      end

      //////////////////////////////
      // rx and tx correction
      //////////////////////////////
      for (int k = 0; k < 8; k++) begin
         for (int c = 0; c < NUM_CHANNELS; c++)
            wr_data[c] = ($random(seed) & 32'hFFFF_FFF8) | 32'((k + 3 * c) % 8);
         write_all(SR_FE_CTRL);
         for (int n = 0; n < 4; n++) begin
            for (int d = 0; d < NUM_DBOARDS; d++) begin
               adc[d] = $random(seed);
               tx_sample[d] = $random(seed);
            end
            rx_running = 4'($random(seed));
            tx_valid = 2'($random(seed));
            if (n == 0) begin   // most negative rails
               adc[0] = 32'h8000_8000;
               tx_sample[1] = 32'h8000_7FFF;
               rx_running = 4'hF;
               tx_valid = 2'b11;
            end
            @(posedge radio_clk);
            #1;
            for (int c = 0; c < NUM_CHANNELS; c++) begin
               expect_value($sformatf("rx sample ch%0d ctrl%0d", c, m_ctrl[c]),
                  64'(corrected_word(m_ctrl[c], rx_running[c], adc[c/2])), 64'(rx_sample[c]));
               expect_value($sformatf("rx valid ch%0d", c), 64'(rx_running[c]), 64'(rx_valid[c]));
            end
            for (int d = 0; d < NUM_DBOARDS; d++)
               expect_value($sformatf("dac db%0d ctrl%0d", d, m_ctrl[2*d]),
                  64'(corrected_word(m_ctrl[2*d], tx_valid[d], tx_sample[d])), 64'(dac[d]));
            @(negedge radio_clk);
         end
      end

      // pps pulse lands two edges after the first sample and time sync one edge after it
      pps = 1'b1;
      time_sync = 1'b1;
      for (int j = 0; j < 10; j++) begin
         @(posedge radio_clk);
         #1;
         expect_value($sformatf("pps pulse edge %0d", j), 64'(j == 2), 64'(pps_pulse));
         expect_value($sformatf("time sync edge %0d", j), 64'(j >= 1 && j <= 5),
                      64'(time_sync_out));
         @(negedge radio_clk);
         if (j == 4) begin
            pps = 1'b0;
            time_sync = 1'b0;
         end
      end

      @(negedge radio_clk);
      @(negedge radio_clk);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   //////////////////////////////
   // checker and timeout
   //////////////////////////////
   always @(negedge radio_clk) begin
      while (chk_name_q.size() > 0) begin
         cur_name = chk_name_q.pop_front();
         cur_exp  = chk_exp_q.pop_front();
         cur_act  = chk_act_q.pop_front();
         checks++;
         if (cur_act !== cur_exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", cur_name, cur_exp, cur_act);
         end
      end
   end

   always @(posedge radio_clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
         $display("Something failed");
         $finish;
      end
   end

endmodule

//--- x300_radio_frontend.f
+incdir+tb
hw/radio_fe_pkg.sv
hw/radio_timing_sync.sv
hw/fe_settings_regs.sv
hw/fe_iq_correct.sv
hw/db_pin_map.sv
hw/x300_radio_frontend.sv
tb/tb_x300_radio_frontend.sv

//--- Makefile
# Verilator build and run of the radio front end testbench

VERILATOR ?= verilator
TOP       ?= tb_x300_radio_frontend
FILELIST  ?= x300_radio_frontend.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
